/* Makefile */
# Verilator build and run for the LSU testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_lsu -f all.f -Mdir obj_dir -o Vtb_lsu

run: compile
	./obj_dir/Vtb_lsu | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
lsu_cfg_pkg.sv
lsu_types_pkg.sv
lsu_addr_gen.sv
lsu_stbuf_ptrs.sv
lsu_dccm_ctl.sv
lsu_load_align.sv
lsu_top.sv
tb_dccm_mem.sv
tb_lsu.sv

/* lsu_addr_gen.sv */
//****************************************
// Address generation, access checks and d/m/r control pipeline
// A failing access only raises error_m, it never reaches the DCCM
// flush_r kills the store sitting in r and nothing younger
//****************************************
`timescale 1ns/1ps

module lsu_addr_gen (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   valid_d,
   input  logic                                   load_d,
   input  logic                                   store_d,
   input  logic [1:0]                             size_d,
   input  logic                                   unsign_d,
   input  logic [31:0]                            rs1_d,
   input  logic [11:0]                            offset_d,
   input  logic [31:0]                            store_data_d,
   input  logic                                   flush_r,
   output logic                                   rden_d,
   output logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] rd_index_d,
   output logic                                   load_ok_m,
   output logic [1:0]                             size_m,
   output logic                                   unsign_m,
   output logic [1:0]                             byte_off_m,
   output logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] index_m,
   output logic                                   commit_r,
   output logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] index_r,
   output logic [31:0]                            lane_data_r,
   output logic [3:0]                             byteen_r,
   output logic                                   valid_m,
   output logic                                   valid_r,
   output logic                                   error_m
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   lsu_addr_u   addr_d;        // Effective address
   logic        misalign_d;
   logic        in_dccm_d;
   logic        ok_d;          // Access passes every check
   logic [3:0]  byteen_d;
   logic        store_ok_m;
   logic        store_ok_r;
   logic [31:0] lane_data_m;
   logic [3:0]  byteen_m;

   //****************************************
   // Decode stage
   //****************************************
   assign addr_d.flat = rs1_d + {{20{offset_d[11]}}, offset_d};  // Sign-extended offset

   // Natural alignment, size 3 always fails
   assign misalign_d = (size_d == SIZE_HALF) ? addr_d.flat[0] :
                       (size_d == SIZE_WORD) ? |addr_d.flat[1:0] :
                       (size_d != SIZE_BYTE);

   assign in_dccm_d  = (addr_d.f.region == DCCM_REGION);
   assign ok_d       = valid_d & in_dccm_d & ~misalign_d;

   assign rden_d     = ok_d & load_d;          // Read issued in d, data back in m
   assign rd_index_d = addr_d.f.word_index;

   // Byte enables in word lanes
   always_comb begin
      case (size_d)
         SIZE_BYTE: byteen_d = 4'b0001;
         SIZE_HALF: byteen_d = 4'b0011;
         default:   byteen_d = 4'b1111;
      endcase
      byteen_d = byteen_d << addr_d.f.byte_off;
   end

   //****************************************
   // d -> m -> r control
   //****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_m    <= 1'b0;
         load_ok_m  <= 1'b0;
         store_ok_m <= 1'b0;
         error_m    <= 1'b0;
         valid_r    <= 1'b0;
         store_ok_r <= 1'b0;
      end else begin
         valid_m    <= valid_d;
         load_ok_m  <= ok_d & load_d;
         store_ok_m <= ok_d & store_d;
         error_m    <= valid_d & ~ok_d;   // Misaligned or outside the DCCM
         valid_r    <= valid_m;
         store_ok_r <= store_ok_m;
      end
   end

   // Payload follows the control bits
   always_ff @(posedge clk) begin
      size_m      <= size_d;
      unsign_m    <= unsign_d;
      byte_off_m  <= addr_d.f.byte_off;
      index_m     <= addr_d.f.word_index;
      lane_data_m <= store_data_d << {addr_d.f.byte_off, 3'b000};  // Data moved to its lanes
      byteen_m    <= byteen_d;
      index_r     <= index_m;
      lane_data_r <= lane_data_m;
      byteen_r    <= byteen_m;
   end

   assign commit_r = store_ok_r & ~flush_r;   // Killed stores never reach the buffer

   a_one_op: assert property (@(posedge clk) disable iff (rst)
      valid_d |-> !(load_d && store_d));

endmodule

/* lsu_cfg_pkg.sv */
//****************************************
// DCCM memory map and store-buffer sizing for the LSU
// The DCCM is one 32-bit word wide, 4 KB, at a fixed base
// STBUF_DEPTH must be a power of two so that the pointers wrap freely
//****************************************
package lsu_cfg_pkg;

   //****************************************
   // DCCM region
   //****************************************
   localparam logic [31:0] DCCM_BASE       = 32'hF004_0000;  // Region start, 4 KB aligned
   localparam int          DCCM_ADDR_BITS  = 12;             // 4 KB region
   localparam int          DCCM_INDEX_BITS = 10;             // Word index into the DCCM

   // Upper address bits that select the region
   localparam logic [31-DCCM_ADDR_BITS:0] DCCM_REGION = DCCM_BASE[31:DCCM_ADDR_BITS];

   //****************************************
   // Store buffer
   //****************************************
   localparam int STBUF_DEPTH     = 4;  // Entries
   localparam int STBUF_PTR_BITS  = 2;  // log2 of depth
   localparam int STBUF_CNT_BITS  = 3;  // Holds 0 to depth
   localparam int STBUF_STALL_LVL = 2;  // Leaves room for stores already in m and r

endpackage

/* lsu_dccm_ctl.sv */
//****************************************
// Store-buffer entries, load forwarding and the DCCM port
// A load in d always owns the port, the buffer drains otherwise
// Forwarding is whole-word index match with per-byte merge
//****************************************
`timescale 1ns/1ps

module lsu_dccm_ctl (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   rden_d,
   input  logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] rd_index_d,
   input  logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] index_m,
   input  logic                                   load_ok_m,
   input  logic                                   commit_r,
   input  logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] index_r,
   input  logic [31:0]                            lane_data_r,
   input  logic [3:0]                             byteen_r,
   input  logic [lsu_cfg_pkg::STBUF_PTR_BITS-1:0]  wr_ptr,
   input  logic [lsu_cfg_pkg::STBUF_PTR_BITS-1:0]  rd_ptr,
   input  logic                                   empty,
   input  logic [31:0]                            dccm_rd_data,
   output logic                                   pop,
   output logic                                   dccm_en,
   output logic                                   dccm_we,
   output logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] dccm_index,
   output logic [31:0]                            dccm_wr_data,
   output logic [3:0]                             dccm_byteen,
   output logic [31:0]                            fwd_data_m,
   output logic [3:0]                             fwd_byteen_m
);
   import lsu_cfg_pkg::*;

   logic [STBUF_DEPTH-1:0]     stb_vld;
   logic [DCCM_INDEX_BITS-1:0] stb_index  [STBUF_DEPTH];
   logic [31:0]                stb_data   [STBUF_DEPTH];
   logic [3:0]                 stb_byteen [STBUF_DEPTH];

   //****************************************
   // Entry write and release
   //****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         stb_vld <= '0;
      end else begin
         if (pop)      stb_vld[rd_ptr] <= 1'b0;   // Drained this cycle
         if (commit_r) stb_vld[wr_ptr] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (commit_r) begin
         stb_index[wr_ptr]  <= index_r;
         stb_data[wr_ptr]   <= lane_data_r;
         stb_byteen[wr_ptr] <= byteen_r;
      end
   end

   //****************************************
   // DCCM port
   //****************************************
   assign pop          = ~rden_d & ~empty;   // Oldest entry drains when the port is free
   assign dccm_en      = rden_d | pop;
   assign dccm_we      = pop;
   assign dccm_index   = rden_d ? rd_index_d : stb_index[rd_ptr];
   assign dccm_wr_data = stb_data[rd_ptr];
   assign dccm_byteen  = stb_byteen[rd_ptr];

   //****************************************
   // Forwarding into the load in m
   //****************************************
   always_comb begin
      logic [STBUF_PTR_BITS-1:0] idx;
      fwd_data_m   = dccm_rd_data;   // Unforwarded lanes carry the DCCM word
      fwd_byteen_m = '0;
      idx          = rd_ptr;
      // Oldest first, so a younger entry overwrites an older one
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         idx = rd_ptr + STBUF_PTR_BITS'(i);
         if (load_ok_m && stb_vld[idx] && (stb_index[idx] == index_m)) begin
            for (int b = 0; b < 4; b++) begin
               if (stb_byteen[idx][b]) begin
                  fwd_data_m[8*b +: 8] = stb_data[idx][8*b +: 8];
                  fwd_byteen_m[b]      = 1'b1;
               end
            end
         end
      end
      // Store committing at r is the newest of all
      if (load_ok_m && commit_r && (index_r == index_m)) begin
         for (int b = 0; b < 4; b++) begin
            if (byteen_r[b]) begin
               fwd_data_m[8*b +: 8] = lane_data_r[8*b +: 8];
               fwd_byteen_m[b]      = 1'b1;
            end
         end
      end
   end

   // Drain only takes an entry that holds a committed store
   a_pop_live: assert property (@(posedge clk) disable iff (rst)
      pop |-> stb_vld[rd_ptr]);

endmodule

/* lsu_load_align.sv */
//****************************************
// Load data merge, lane shift and extension in m
// Assumes an aligned access, checked in d
//****************************************
`timescale 1ns/1ps

module lsu_load_align (
   input  logic        load_ok_m,
   input  logic [1:0]  size_m,
   input  logic        unsign_m,
   input  logic [1:0]  byte_off_m,
   input  logic [31:0] dccm_rd_data,
   input  logic [31:0] fwd_data_m,
   input  logic [3:0]  fwd_byteen_m,
   output logic        lsu_load_valid_m,
   output logic [31:0] lsu_result_m
);
   import lsu_types_pkg::*;

   logic [31:0] merged;    // Store-buffer bytes over DCCM bytes
   logic [31:0] shifted;   // Addressed byte moved to lane 0

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = fwd_byteen_m[b] ? fwd_data_m[8*b +: 8] : dccm_rd_data[8*b +: 8];
      end
   end

   assign shifted = merged >> {byte_off_m, 3'b000};

   // Sign or zero fill by size
   always_comb begin
      case (size_m)
         SIZE_BYTE: lsu_result_m = {{24{~unsign_m & shifted[7]}}, shifted[7:0]};
         SIZE_HALF: lsu_result_m = {{16{~unsign_m & shifted[15]}}, shifted[15:0]};
         default:   lsu_result_m = shifted;
      endcase
   end

   assign lsu_load_valid_m = load_ok_m;

endmodule

/* lsu_stbuf_ptrs.sv */
//****************************************
// Store-buffer pointers and occupancy
// Pointers wrap at a power-of-two depth
// Count and stalls follow push/pop one cycle later
//****************************************
`timescale 1ns/1ps

module lsu_stbuf_ptrs (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  push,
   input  logic                                  pop,
   output logic [lsu_cfg_pkg::STBUF_PTR_BITS-1:0] wr_ptr,
   output logic [lsu_cfg_pkg::STBUF_PTR_BITS-1:0] rd_ptr,
   output logic                                  empty,
   output logic                                  store_stall,
   output logic                                  load_stall
);
   import lsu_cfg_pkg::*;

   logic [STBUF_CNT_BITS-1:0] cnt;   // Entries in use
   logic                      full;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;   // Both or neither
         endcase
      end
   end

   assign empty       = (cnt == '0);
   assign full        = (cnt == STBUF_CNT_BITS'(STBUF_DEPTH));
   assign store_stall = (cnt >= STBUF_CNT_BITS'(STBUF_STALL_LVL));  // Room for m and r stores
   assign load_stall  = full;   // Loads yield the port so the buffer drains

   // Decode must have held stores back early enough
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      full |-> !push);

   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      empty |-> !pop);

endmodule

/* lsu_top.sv */
//****************************************
// Load/store unit with private DCCM and store buffer
// Decode holds requests while the matching stall is high
// DCCM read latency is one cycle
//****************************************
`timescale 1ns/1ps

module lsu_top (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   valid_d,
   input  logic                                   load_d,
   input  logic                                   store_d,
   input  logic [1:0]                             size_d,
   input  logic                                   unsign_d,
   input  logic [31:0]                            rs1_d,
   input  logic [11:0]                            offset_d,
   input  logic [31:0]                            store_data_d,
   input  logic                                   flush_r,
   output logic                                   dccm_en,
   output logic                                   dccm_we,
   output logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] dccm_index,
   output logic [31:0]                            dccm_wr_data,
   output logic [3:0]                             dccm_byteen,
   input  logic [31:0]                            dccm_rd_data,
   output logic                                   lsu_load_valid_m,
   output logic [31:0]                            lsu_result_m,
   output logic                                   lsu_error_m,
   output logic                                   lsu_load_stall_any,
   output logic                                   lsu_store_stall_any,
   output logic                                   lsu_idle_any
);
   import lsu_cfg_pkg::*;

   logic                       rden_d;
   logic [DCCM_INDEX_BITS-1:0] rd_index_d;
   logic                       load_ok_m;
   logic [1:0]                 size_m;
   logic                       unsign_m;
   logic [1:0]                 byte_off_m;
   logic [DCCM_INDEX_BITS-1:0] index_m;
   logic                       commit_r;     // Store enters the buffer
   logic [DCCM_INDEX_BITS-1:0] index_r;
   logic [31:0]                lane_data_r;
   logic [3:0]                 byteen_r;
   logic                       valid_m;
   logic                       valid_r;
   logic                       pop;          // Buffer drains to the DCCM
   logic [STBUF_PTR_BITS-1:0]  wr_ptr;
   logic [STBUF_PTR_BITS-1:0]  rd_ptr;
   logic                       empty;
   logic [31:0]                fwd_data_m;
   logic [3:0]                 fwd_byteen_m;

   lsu_addr_gen u_addr_gen (
      .clk, .rst, .valid_d, .load_d, .store_d, .size_d, .unsign_d, .rs1_d,
      .offset_d, .store_data_d, .flush_r, .rden_d, .rd_index_d, .load_ok_m,
      .size_m, .unsign_m, .byte_off_m, .index_m, .commit_r, .index_r,
      .lane_data_r, .byteen_r, .valid_m, .valid_r, .error_m(lsu_error_m)
   );

   lsu_stbuf_ptrs u_stbuf_ptrs (
      .clk, .rst, .push(commit_r), .pop, .wr_ptr, .rd_ptr, .empty,
      .store_stall(lsu_store_stall_any), .load_stall(lsu_load_stall_any)
   );

   lsu_dccm_ctl u_dccm_ctl (
      .clk, .rst, .rden_d, .rd_index_d, .index_m, .load_ok_m, .commit_r,
      .index_r, .lane_data_r, .byteen_r, .wr_ptr, .rd_ptr, .empty,
      .dccm_rd_data, .pop, .dccm_en, .dccm_we, .dccm_index, .dccm_wr_data,
      .dccm_byteen, .fwd_data_m, .fwd_byteen_m
   );

   lsu_load_align u_load_align (
      .load_ok_m, .size_m, .unsign_m, .byte_off_m, .dccm_rd_data,
      .fwd_data_m, .fwd_byteen_m, .lsu_load_valid_m, .lsu_result_m
   );

   // Nothing past d and nothing left to drain
   assign lsu_idle_any = ~valid_m & ~valid_r & empty;

endmodule

/* lsu_types_pkg.sv */
//****************************************
// Access-size encodings and the LSU address view
// Size 3 has no meaning and is treated as an illegal access
//****************************************
package lsu_types_pkg;

   // Access size, as carried from decode
   localparam logic [1:0] SIZE_BYTE = 2'd0;
   localparam logic [1:0] SIZE_HALF = 2'd1;
   localparam logic [1:0] SIZE_WORD = 2'd2;

   //****************************************
   // Effective address, flat or split into fields
   //****************************************
   typedef union packed {
      logic [31:0] flat;                                     // Adder output, alignment check
      struct packed {
         logic [31-lsu_cfg_pkg::DCCM_ADDR_BITS:0] region;    // Compared against the DCCM base
         logic [lsu_cfg_pkg::DCCM_INDEX_BITS-1:0] word_index; // DCCM word address
         logic [1:0]                              byte_off;   // Lane within the word
      } f;
   } lsu_addr_u;

endpackage

/* tb_dccm_mem.sv */
//****************************************
// Behavioral DCCM, one port, byte enables
// Read data appears one cycle after en without we
// Contents start from a fixed address-based pattern
//****************************************
`timescale 1ns/1ps

module tb_dccm_mem (
   input  logic        clk,
   input  logic        en,
   input  logic        we,
   input  logic [9:0]  index,
   input  logic [31:0] wr_data,
   input  logic [3:0]  byteen,
   output logic [31:0] rd_data
);
   logic [31:0] mem [1024];

   initial begin
      for (int i = 0; i < 1024; i++) begin
         mem[i] = (i * 32'h9E37_79B9) ^ 32'h5A5A_0000 ^ i;   // Every index bit matters
      end
   end

   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int b = 0; b < 4; b++) begin
            if (byteen[b]) mem[index][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end else if (en) begin
         rd_data <= mem[index];   // One-cycle read
      end
   end

endmodule

/* tb_lsu.sv */
//****************************************
// Random load/store stream against a byte-level memory model
// Stimulus changes on the falling edge, outputs sampled 1 ns later
// Buffer occupancy is tracked from commits and observed drains
//****************************************
`timescale 1ns/1ps

module tb_lsu;
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   localparam int LIMIT = 200;   // Cycles allowed for any wait

   logic clk, rst, valid_d, load_d, store_d, unsign_d, flush_r;
   logic [1:0]  size_d;
   logic [31:0] rs1_d, store_data_d, dccm_wr_data, dccm_rd_data, lsu_result_m;
   logic [11:0] offset_d;
   logic [9:0]  dccm_index;
   logic [3:0]  dccm_byteen;
   logic dccm_en, dccm_we, lsu_load_valid_m, lsu_error_m;
   logic lsu_load_stall_any, lsu_store_stall_any, lsu_idle_any;

   integer      seed = 32;
   int          errors = 0;
   int          checks = 0;
   int          test_start;
   int          occ = 0;            // Store-buffer entries expected
   logic [7:0]  model_mem [4096];   // DCCM bytes in program order
   logic        touched [1024];
   // Next request
   logic        nx_load, nx_uns, nx_flush;
   logic [1:0]  nx_size;
   logic [31:0] nx_addr, nx_data;
   logic [11:0] nx_off;
   // Requests in flight, index 0 is m and 1 is r
   logic        pv [2], pl [2], pst [2], pu [2], pf [2], pok [2];
   logic [1:0]  psz [2];
   logic [31:0] pa [2], pd [2];
   logic        issued;
   logic        store_stall_seen;

   lsu_top DUT (.*);

   tb_dccm_mem u_mem (
      .clk, .en(dccm_en), .we(dccm_we), .index(dccm_index),
      .wr_data(dccm_wr_data), .byteen(dccm_byteen), .rd_data(dccm_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //****************************************
   // Model helpers
   //****************************************
   function automatic logic legal(input logic [31:0] a, input logic [1:0] sz);
      logic aligned;
      aligned = (sz == SIZE_BYTE) || (sz == SIZE_HALF && !a[0]) ||
                (sz == SIZE_WORD && a[1:0] == 2'b00);
      return aligned && (a[31:12] == DCCM_BASE[31:12]);
   endfunction

   function automatic int nbytes(input logic [1:0] sz);
      return (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
   endfunction

   function automatic logic [31:0] expect_load(input logic [31:0] a, input logic [1:0] sz,
                                               input logic uns);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < nbytes(sz); k++) v[8*k +: 8] = model_mem[a[11:0] + 12'(k)];
      if (sz == SIZE_BYTE && !uns && v[7])  v[31:8]  = '1;   // Sign fill
      if (sz == SIZE_HALF && !uns && v[15]) v[31:16] = '1;
      return v;
   endfunction

   task automatic apply_store(input logic [31:0] a, input logic [31:0] d, input logic [1:0] sz);
      for (int k = 0; k < nbytes(sz); k++) model_mem[a[11:0] + 12'(k)] = d[8*k +: 8];
      touched[a[11:2]] = 1'b1;
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   //****************************************
   // Stimulus
   //****************************************
   task automatic gen_op(input int load_pct, input int bad_pct, input int flush_pct,
                         input int word);
      int u;
      u        = $unsigned($random(seed)) % 100;
      nx_load  = (u < load_pct);
      nx_size  = 2'($unsigned($random(seed)) % 3);
      nx_uns   = $random(seed) & 1;
      nx_data  = $random(seed);
      nx_off   = 12'($random(seed));
      u        = (word >= 0) ? word : 100 + $unsigned($random(seed)) % 8;   // Few hot words
      nx_addr  = DCCM_BASE + 32'(u * 4);
      if (nx_size == SIZE_BYTE) nx_addr += 32'($unsigned($random(seed)) % 4);
      if (nx_size == SIZE_HALF) nx_addr += 32'(($unsigned($random(seed)) % 2) * 2);
      if ($unsigned($random(seed)) % 100 < bad_pct) begin
         if (nx_size != SIZE_BYTE && ($random(seed) & 1)) nx_addr += 32'd1;   // Misaligned
         else nx_addr += 32'h0000_1000;                                      // Outside
      end
      nx_flush = !nx_load && ($unsigned($random(seed)) % 100 < flush_pct);
   endtask

   // One cycle: r-stage commit or flush, d-stage drive, m-stage check
   task automatic step(input logic want);
      logic commit;   // Store at r enters the buffer at the next edge
      @(negedge clk);
      commit  = pv[1] && pst[1] && pok[1] && !pf[1];
      flush_r = pv[1] && pst[1] && pok[1] && pf[1];
      if (commit) apply_store(pa[1], pd[1], psz[1]);
      issued = want && !(nx_load ? lsu_load_stall_any : lsu_store_stall_any);
      valid_d      = issued;
      load_d       = issued && nx_load;
      store_d      = issued && !nx_load;
      size_d       = nx_size;
      unsign_d     = nx_uns;
      offset_d     = nx_off;
      rs1_d        = nx_addr - {{20{nx_off[11]}}, nx_off};
      store_data_d = nx_data;
      #1;
      if (lsu_store_stall_any) store_stall_seen = 1'b1;
      check_eq("lsu_store_stall_any", 32'(lsu_store_stall_any), 32'(occ >= STBUF_STALL_LVL));
      check_eq("lsu_load_stall_any", 32'(lsu_load_stall_any), 32'(occ == STBUF_DEPTH));
      check_eq("lsu_idle_any", 32'(lsu_idle_any), 32'(!pv[0] && !pv[1] && occ == 0));
      if (pv[0] && !pok[0]) begin
         check_eq("lsu_error_m", 32'(lsu_error_m), 32'd1);
         check_eq("lsu_load_valid_m", 32'(lsu_load_valid_m), 32'd0);
      end else begin
         check_eq("lsu_error_m", 32'(lsu_error_m), 32'd0);
         check_eq("lsu_load_valid_m", 32'(lsu_load_valid_m), 32'(pv[0] && pl[0]));
         if (pv[0] && pl[0])
            check_eq("lsu_result_m", lsu_result_m, expect_load(pa[0], psz[0], pu[0]));
      end
      // A drain leaves the buffer at the next edge
      if (dccm_en && dccm_we) begin
         checks++;
         assert (occ > 0) else begin
            errors++;
            $display("Store buffer drained while empty at %0t", $time);
         end
         occ--;
      end
      if (commit) occ++;
      pv[1]  = pv[0];
      pl[1]  = pl[0];
      pst[1] = pst[0];
      pu[1]  = pu[0];
      pf[1]  = pf[0];
      pok[1] = pok[0];
      psz[1] = psz[0];
      pa[1]  = pa[0];
      pd[1]  = pd[0];
      pv[0]  = issued;
      pl[0]  = nx_load;
      pst[0] = !nx_load;
      pu[0]  = nx_uns;
      pf[0]  = nx_flush;
      pok[0] = legal(nx_addr, nx_size);
      psz[0] = nx_size;
      pa[0]  = nx_addr;
      pd[0]  = nx_data;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (!(lsu_idle_any && !pv[0] && !pv[1]) && n < LIMIT) begin
         step(1'b0);
         n++;
      end
      if (!(lsu_idle_any && !pv[0] && !pv[1])) abort_run("LSU never went idle");
   endtask

   task automatic wait_store_clear();
      int n;
      n = 0;
      while (lsu_store_stall_any && n < LIMIT) begin
         step(1'b0);
         n++;
      end
      if (lsu_store_stall_any) abort_run("store stall never cleared");
   endtask

   task automatic report(input string name);
      $display("%-24s %s  (%0d checks so far)", name,
               (errors == test_start) ? "ok" : "errors", checks);
      test_start = errors;
   endtask

   //****************************************
   // Test sequence
   //****************************************
   initial begin
      rst          = 1'b1;
      valid_d      = 1'b0;
      load_d       = 1'b0;
      store_d      = 1'b0;
      flush_r      = 1'b0;
      size_d       = '0;
      unsign_d     = 1'b0;
      rs1_d        = '0;
      offset_d     = '0;
      store_data_d = '0;
      for (int i = 0; i < 4096; i++) begin
         model_mem[i] = 8'((((i / 4) * 32'h9E37_79B9) ^ 32'h5A5A_0000 ^ (i / 4)) >> (8 * (i % 4)));
      end
      for (int i = 0; i < 1024; i++) touched[i] = 1'b0;
      for (int s = 0; s < 2; s++) pv[s] = 1'b0;
      store_stall_seen = 1'b0;
      gen_op(0, 0, 0, -1);
      repeat (3) @(posedge clk);
      @(negedge clk) rst = 1'b0;
      test_start = 0;

      repeat (400) begin
         gen_op(50, 0, 0, -1);
         step(1'b1);
      end
      report("loads and forwarding");
      repeat (200) begin
         gen_op(50, 40, 0, -1);
         step(1'b1);
      end
      report("failing accesses");
      repeat (200) begin
         gen_op(50, 0, 40, -1);
         step(1'b1);
      end
      report("flushed stores");

      // Stores from an empty buffer, then loads holding the port
      wait_idle();
      store_stall_seen = 1'b0;
      repeat (3) begin
         gen_op(0, 0, 0, -1);
         step(1'b1);
      end
      repeat (6) begin
         gen_op(100, 0, 0, -1);
         step(1'b1);
      end
      wait_store_clear();
      checks++;
      assert (store_stall_seen) else begin
         errors++;
         $display("Store stall never rose during the store burst");
      end
      repeat (60) begin
         gen_op(50, 0, 0, -1);
         step(1'b1);
      end
      report("back-pressure");

      wait_idle();
      for (int w = 0; w < 1024; w++) begin
         if (touched[w]) begin
            gen_op(100, 0, 0, w);
            nx_size = SIZE_WORD;
            nx_addr = DCCM_BASE + 32'(w * 4);
            step(1'b1);
         end
      end
      repeat (2) step(1'b0);
      report("idle and final contents");

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
